/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rv_core
	@out="$$(./obj_dir/Vtb_rv_core)"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core;

    localparam int CLK_PERIOD = 20;
    localparam int IMEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 2 * IMEM_WORDS + 50;
    localparam logic [31:0] HALT_ADDR = 32'd1020;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [64];
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [64];
    logic [31:0] m_pc;
    logic        exp_we;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    integer      seed;
    int          cycles;
    int          checks;
    int          errors;
    int          halt_hits;

    rv_core u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer in the same cycle
    // Data window starts at 0x100
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the program did not reach its halt loop in %0d cycles",
                     TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000: return sub ? x - y : x + y;
            3'b010: return {31'd0, $signed(x) < $signed(y)};
            3'b011: return {31'd0, x < y};
            3'b100: return x ^ y;
            3'b110: return x | y;
            3'b111: return x & y;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
        case (f3)
            3'b000: return x == y;
            3'b001: return x != y;
            3'b100: return $signed(x) < $signed(y);
            3'b101: return $signed(x) >= $signed(y);
            3'b110: return x < y;
            3'b111: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    task automatic gen_program();
        int          i;
        int          k;
        int          t;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [2:0]  f3;
        logic [11:0] so;
        logic [12:0] bo;
        logic [20:0] jo;
        // Seed x1..x31 with LUI then ADDI
        for (i = 1; i < 32; i++) begin
            w = $random(seed);
            rd = 5'(i);
            imem[2 * i - 2] = {w[31:12], rd, 7'b0110111};
            imem[2 * i - 1] = {w[11:0], rd, 3'b000, rd, 7'b0010011};
        end
        i = 62;
        while (i < IMEM_WORDS - 1) begin
            w = $random(seed);
            rd = 5'(rnd(32));
            r1 = 5'(rnd(32));
            r2 = 5'(rnd(32));
            f3 = 3'(rnd(8));
            so = 12'(256 + 4 * rnd(64));
            t = i + 1 + int'(rnd(8));
            if (t > IMEM_WORDS - 1) begin
                t = IMEM_WORDS - 1;
            end
            k = int'(rnd(16));
            if (i % 8 == 0) begin
                k = 10;
            end
            if (f3 == 3'b001 || f3 == 3'b101) begin
                f3 = 3'b000;
            end
            case (k)
                0, 1, 2, 3: imem[i] = {w[31:20], r1, f3, rd, 7'b0010011};
                4, 5, 6, 7: imem[i] = {1'b0, w[0] & (f3 == 3'b000), 5'd0, r2, r1, f3, rd,
                                       7'b0110011};
                8: imem[i] = {w[31:12], rd, 7'b0110111};
                9: imem[i] = {w[31:12], rd, 7'b0010111};
                10, 11: imem[i] = {so[11:5], r2, 5'd0, 3'b010, so[4:0], 7'b0100011};
                12: imem[i] = {so, 5'd0, 3'b010, rd, 7'b0000011};
                13: begin
                    bo = 13'((t - i) * 4);
                    f3 = 3'(rnd(8));
                    if (f3 == 3'b010 || f3 == 3'b011) begin
                        f3 = 3'b000;
                    end
                    imem[i] = {bo[12], bo[10:5], r2, r1, f3, bo[4:1], bo[11], 7'b1100011};
                end
                14: begin
                    jo = 21'((t - i) * 4);
                    imem[i] = {jo[20], jo[10:1], jo[11], jo[19:12], rd, 7'b1101111};
                end
                default: begin
                    if (i < IMEM_WORDS - 3) begin
                        // Target address goes into r1 ahead of the JALR
                        t = t + 1;
                        if (t > IMEM_WORDS - 1) begin
                            t = IMEM_WORDS - 1;
                        end
                        r1 = 5'(1 + rnd(31));
                        imem[i] = {12'(t * 4), 5'd0, 3'b000, r1, 7'b0010011};
                        i++;
                        // Odd offset needs bit 0 cleared
                        imem[i] = {11'd0, w[0], r1, 3'b000, rd, 7'b1100111};
                    end else begin
                        imem[i] = {w[31:20], r1, 3'b000, rd, 7'b0010011};
                    end
                end
            endcase
            i++;
        end
        // Jump to itself
        imem[IMEM_WORDS - 1] = {20'd0, 5'd0, 7'b1101111};
    endtask

    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wen;
        logic [2:0]  f3;
        ins = imem[m_pc[9:2]];
        f3 = ins[14:12];
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        addr = a + imm_i;
        nxt = m_pc + 32'd4;
        wen = 1'b0;
        res = 32'd0;
        exp_we = 1'b0;
        exp_addr = 32'd0;
        exp_wdata = 32'd0;
        case (ins[6:0])
            7'b0110111: begin
                wen = 1'b1;
                res = {ins[31:12], 12'h000};
            end
            7'b0010111: begin
                wen = 1'b1;
                res = m_pc + {ins[31:12], 12'h000};
            end
            7'b1101111: begin
                wen = 1'b1;
                res = m_pc + 32'd4;
                nxt = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                wen = 1'b1;
                res = m_pc + 32'd4;
                nxt = addr & ~32'd1;
            end
            7'b1100011: begin
                if (branch_taken(f3, a, b)) begin
                    nxt = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b0000011: begin
                wen = (f3 == 3'b010);
                res = m_mem[addr[7:2]];
            end
            7'b0100011: begin
                if (f3 == 3'b010) begin
                    exp_we = 1'b1;
                    exp_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_wdata = b;
                    m_mem[exp_addr[7:2]] = b;
                end
            end
            7'b0010011: begin
                wen = (f3 != 3'b001) && (f3 != 3'b101);
                res = arith(f3, 1'b0, a, imm_i);
            end
            7'b0110011: begin
                wen = (f3 != 3'b001) && (f3 != 3'b101);
                res = arith(f3, ins[30], a, b);
            end
            default: ;
        endcase
        if (wen && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = res;
        end
        m_pc = nxt;
    endtask

    task automatic check_cycle();
        checks++;
        assert (imem_addr === m_pc) else begin
            errors++;
            $display("FAIL %0t: imem_addr %h, expected %h", $time, imem_addr, m_pc);
        end
        if (m_pc == HALT_ADDR) begin
            halt_hits++;
        end
        model_step();
        checks++;
        assert (dmem_we === exp_we) else begin
            errors++;
            $display("FAIL %0t: dmem_we %b, expected %b", $time, dmem_we, exp_we);
        end
        if (exp_we && dmem_we) begin
            checks++;
            assert (dmem_addr === exp_addr && dmem_wdata === exp_wdata) else begin
                errors++;
                $display("FAIL %0t: store %h to %h, expected %h to %h", $time,
                         dmem_wdata, dmem_addr, exp_wdata, exp_addr);
            end
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %s finished: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        int          c0;
        int          e0;
        logic [31:0] fill;
        logic [31:0] first_word;
        clk = 1'b0;
        arst_n = 1'b0;
        seed = 33;
        cycles = 0;
        checks = 0;
        errors = 0;
        halt_hits = 0;
        gen_program();
        for (int k = 0; k < 64; k++) begin
            fill = 32'h100 + 32'(k) * 4;
            dmem[k] = fill * 32'h9E37_79B1;
            m_mem[k] = dmem[k];
        end
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = 32'd0;
        end
        m_pc = `RV_RESET_PC;

        // A store sits at the reset PC while reset is held
        first_word = imem[0];
        imem[0] = {7'd8, 5'd0, 5'd0, 3'b010, 5'd0, 7'b0100011};

        c0 = checks;
        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            checks++;
            assert (imem_addr === `RV_RESET_PC && dmem_we === 1'b0) else begin
                errors++;
                $display("FAIL %0t: in reset imem_addr %h dmem_we %b", $time,
                         imem_addr, dmem_we);
            end
        end
        @(negedge clk);
        imem[0] = first_word;
        arst_n = 1'b1;
        report_test("reset", c0, e0);

        c0 = checks;
        e0 = errors;
        while (halt_hits < 2) begin
            #(CLK_PERIOD / 4);
            check_cycle();
            @(negedge clk);
        end
        report_test("program", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 64; k++) begin
            checks++;
            assert (dmem[k] === m_mem[k]) else begin
                errors++;
                $display("FAIL %0t: data word %0d is %h, expected %h", $time, k,
                         dmem[k], m_mem[k]);
            end
        end
        report_test("final memory", c0, e0);

        $display("tests: 3, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/rv_pkg.sv
common/ctrl_if.sv
core/instr_ctl.sv
core/imm_gen.sv
core/reg_file.sv
core/alu.sv
core/rv_core.sv
bench/tb_rv_core.sv

/* common/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
    logic       a_sel;
    logic       b_sel;
    logic [3:0] alu_sel;
    logic       mem_wr;
    logic       reg_wen;
    logic       pc_sel;
    logic       br_un;
    logic [2:0] imm_sel;
    logic [1:0] wb_sel;
    // Compare results back from the datapath
    logic       br_eq;
    logic       br_lt;

    modport decoder (
        output a_sel, b_sel, alu_sel, mem_wr, reg_wen, pc_sel, br_un, imm_sel, wb_sel,
        input  br_eq, br_lt
    );

    modport datapath (
        input  a_sel, b_sel, alu_sel, mem_wr, reg_wen, pc_sel, br_un, imm_sel, wb_sel,
        output br_eq, br_lt
    );
endinterface

`default_nettype wire

/* common/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// Integer register count, x0 included
`define RV_NREGS 32

// Fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Same codes the decoder has always used for add, slt and pass-b
    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_ADD    = 4'b0010,
        ALU_SUB    = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLT    = 4'b1000,
        ALU_PASS_B = 4'b1001,
        ALU_SLTU   = 4'b1010
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'h1,
        IMM_S = 3'h2,
        IMM_B = 3'h3,
        IMM_U = 3'h4,
        IMM_J = 3'h5
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM = 2'b00,
        WB_ALU = 2'b01,
        WB_PC4 = 2'b10
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_t;

    // One instruction word, viewed in each encoding format
    typedef union packed {
        r_t r;
        i_t i;
        s_t s;
        b_t b;
        u_t u;
        j_t j;
    } instr_u;

endpackage

`default_nettype wire

/* core/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_e     op,
    output logic [`RV_XLEN-1:0] y
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: y = a + b;
            rv_pkg::ALU_SUB: y = a - b;
            // Compares give 0 or 1
            rv_pkg::ALU_SLT: y = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_AND: y = a & b;
            rv_pkg::ALU_OR: y = a | b;
            rv_pkg::ALU_XOR: y = a ^ b;
            // LUI passes the immediate through
            rv_pkg::ALU_PASS_B: y = b;
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* core/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module imm_gen (
    input  rv_pkg::instr_u       instr,
    input  rv_pkg::imm_sel_e     imm_sel,
    output logic [`RV_XLEN-1:0]  imm
);

    always_comb begin
        case (imm_sel)
            rv_pkg::IMM_I: begin
                imm = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            rv_pkg::IMM_S: begin
                imm = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            rv_pkg::IMM_B: begin
                imm = {{(`RV_XLEN-12){instr.b.imm12}}, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm = {instr.u.imm, 12'h000};
            end
            rv_pkg::IMM_J: begin
                imm = {{(`RV_XLEN-20){instr.j.imm20}}, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* core/instr_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module instr_ctl (
    input  rv_pkg::instr_u instr,
    ctrl_if.decoder        ctrl
);

    always_comb begin
        // No-op by default: no writes, fall through to pc + 4
        ctrl.a_sel   = 1'b0;
        ctrl.b_sel   = 1'b1;
        ctrl.alu_sel = rv_pkg::ALU_ADD;
        ctrl.mem_wr  = 1'b0;
        ctrl.reg_wen = 1'b0;
        ctrl.imm_sel = rv_pkg::IMM_I;
        ctrl.br_un   = 1'b0;
        ctrl.pc_sel  = 1'b0;
        ctrl.wb_sel  = rv_pkg::WB_ALU;

        case (instr.r.opcode)
            rv_pkg::OPC_LUI: begin
                ctrl.alu_sel = rv_pkg::ALU_PASS_B;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_U;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.a_sel   = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_U;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.a_sel   = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_J;
                ctrl.pc_sel  = 1'b1;
                ctrl.wb_sel  = rv_pkg::WB_PC4;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.reg_wen = 1'b1;
                ctrl.pc_sel  = 1'b1;
                ctrl.wb_sel  = rv_pkg::WB_PC4;
            end
            rv_pkg::OPC_BRANCH: begin
                // Target is pc + imm through the ALU
                ctrl.a_sel   = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_B;
                case (instr.b.funct3)
                    3'b000: ctrl.pc_sel = ctrl.br_eq;
                    3'b001: ctrl.pc_sel = !ctrl.br_eq;
                    3'b100: ctrl.pc_sel = ctrl.br_lt;
                    3'b101: ctrl.pc_sel = !ctrl.br_lt;
                    3'b110: begin
                        ctrl.br_un  = 1'b1;
                        ctrl.pc_sel = ctrl.br_lt;
                    end
                    3'b111: begin
                        ctrl.br_un  = 1'b1;
                        ctrl.pc_sel = !ctrl.br_lt;
                    end
                    default: ;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                // Word loads only
                if (instr.i.funct3 == 3'b010) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.wb_sel  = rv_pkg::WB_MEM;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (instr.s.funct3 == 3'b010) begin
                    ctrl.mem_wr  = 1'b1;
                    ctrl.imm_sel = rv_pkg::IMM_S;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.reg_wen = 1'b1;
                case (instr.i.funct3)
                    3'b000: ctrl.alu_sel = rv_pkg::ALU_ADD;
                    3'b010: ctrl.alu_sel = rv_pkg::ALU_SLT;
                    3'b011: ctrl.alu_sel = rv_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_sel = rv_pkg::ALU_XOR;
                    3'b110: ctrl.alu_sel = rv_pkg::ALU_OR;
                    3'b111: ctrl.alu_sel = rv_pkg::ALU_AND;
                    // Shifts are not supported
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP: begin
                ctrl.b_sel   = 1'b0;
                ctrl.reg_wen = 1'b1;
                case (instr.r.funct3)
                    3'b000: begin
                        if (instr.r.funct7[5]) begin
                            ctrl.alu_sel = rv_pkg::ALU_SUB;
                        end else begin
                            ctrl.alu_sel = rv_pkg::ALU_ADD;
                        end
                    end
                    3'b010: ctrl.alu_sel = rv_pkg::ALU_SLT;
                    3'b011: ctrl.alu_sel = rv_pkg::ALU_SLTU;
                    3'b100: ctrl.alu_sel = rv_pkg::ALU_XOR;
                    3'b110: ctrl.alu_sel = rv_pkg::ALU_OR;
                    3'b111: ctrl.alu_sel = rv_pkg::ALU_AND;
                    default: ctrl.reg_wen = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* core/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic [4:0]          rd_addr,
    input  logic [`RV_XLEN-1:0] rd_data,
    input  logic                wen,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* core/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_core (
    input  logic                clk,
    input  logic                arst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                dmem_we,
    input  logic [`RV_XLEN-1:0] dmem_rdata
);

    rv_pkg::instr_u      instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] wb_data;

    ctrl_if ctrl ();

    assign instr     = imem_rdata;
    assign imem_addr = pc;

    instr_ctl u_instr_ctl (
        .instr (instr),
        .ctrl  (ctrl.decoder)
    );

    imm_gen u_imm_gen (
        .instr   (instr),
        .imm_sel (rv_pkg::imm_sel_e'(ctrl.imm_sel)),
        .imm     (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (instr.r.rs1),
        .rs2_addr (instr.r.rs2),
        .rd_addr  (instr.r.rd),
        .rd_data  (wb_data),
        .wen      (ctrl.reg_wen),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Branch comparator
    assign ctrl.br_eq = (rs1_data == rs2_data);
    assign ctrl.br_lt = ctrl.br_un ? (rs1_data < rs2_data)
                                   : ($signed(rs1_data) < $signed(rs2_data));

    assign alu_a = ctrl.a_sel ? pc : rs1_data;
    assign alu_b = ctrl.b_sel ? imm : rs2_data;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (rv_pkg::alu_op_e'(ctrl.alu_sel)),
        .y  (alu_y)
    );

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_MEM: wb_data = dmem_rdata;
            rv_pkg::WB_PC4: wb_data = pc_plus4;
            default: wb_data = alu_y;
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'd4;
    // Bit 0 cleared for JALR targets
    assign pc_next  = ctrl.pc_sel ? {alu_y[`RV_XLEN-1:1], 1'b0} : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign dmem_addr  = alu_y;
    assign dmem_wdata = rs2_data;
    // No store strobe while held in reset
    assign dmem_we    = ctrl.mem_wr & arst_n;

endmodule

`default_nettype wire
